/* dv/seq_patterns.txt */
// Program image from 0x000, one instruction word per entry; steps from 0x100
// Step columns: ctl ram acc exp_addr exp_reg, three steps per line
// ctl bits: 15:12 test, 5 iack, 4 mask clear, 3 irq, 2 cen, 1 random data, 0 reg don't-care
@001 1040
@010 0000 0000 0000 1020
@020 2030 0100 5000 0050 3200
@030 3000
@040 0200 3100
@050 0000 5100 1234 0100 6200 0200 7300 0300
@058 7000 0000 0800 0000 0000 a000 0000 0000
@060 0000 8103 0000 0000 8002 9000
@100
0026 0000 0000 0010 0000  0003 0000 0000 0011 0000  0003 0000 0000 0011 0000
0007 0000 0000 0011 0000  0007 0000 0000 0012 0000
1007 0000 0000 0013 0000  1007 0000 0000 0020 0000  1007 0000 0000 0030 0000
1006 0000 0000 0021 0021  1007 0000 0000 0022 0000  1007 0000 0000 0023 0000
1007 0000 0000 0024 0000  1006 0000 0000 0050 0050
2007 0000 0000 0051 0000  2007 0000 0000 0052 0000  2006 0000 0000 0053 1234
2005 beef 0000 0054 0000  2006 0000 0000 0055 beef  2005 0000 0a85 0056 0000
2006 0000 0000 0057 fa85  2005 0000 4321 0058 0000  2006 0000 0000 0059 4321
2006 0000 0000 005a 4321  2006 0000 0000 005b 3da6
300f 0000 0000 005c 0000  3027 0000 0000 0001 0000  300e 0000 0000 0040 005d
3007 0000 0000 0041 0000  300f 0000 0000 005d 0000  300f 0000 0000 005e 0000
301f 0000 0000 005f 0000  300f 0000 0000 0060 0000  3027 0000 0000 0001 0000
3006 0000 0000 0040 0061  3007 0000 0000 0041 0000
4007 0000 0000 0061 0000  400f 0000 0000 0062 0000  400f 0000 0000 0063 0000
400f 0000 0000 0062 0000  400f 0000 0000 0063 0000  400f 0000 0000 0062 0000
400f 0000 0000 0063 0000  4007 0000 0000 0064 0000  4007 0000 0000 0062 0000
4007 0000 0000 0063 0000  4007 0000 0000 0062 0000  4007 0000 0000 0063 0000
5006 0000 0000 0065 3da6  5007 0000 0000 0065 0000  500f 0000 0000 0065 0000
5007 0000 0000 0065 0000
ffff 0000 0000 0000 0000

/* filelist.f */
verilog/dsp_seq_pkg.sv
verilog/instr_decode.sv
verilog/rom_aau.sv
verilog/dsp_seq_top.sv
dv/dsp_seq_checker.sv
dv/dsp_seq_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dsp_seq_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/dsp_seq_tb.sv */
`timescale 1ns/1ns

module dsp_seq_tb;

    localparam int          RESET_CYCLES = 16;
    localparam int          STEP_BASE    = 256;    // First step entry in the pattern image
    localparam int          STEP_WORDS   = 5;      // ctl, ram, acc, addr, reg
    localparam int          MAX_STEPS    = 150;
    localparam logic [15:0] START_PC     = 16'h0010;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        ext_irq;
    logic        irq_mask_clear;
    logic [15:0] rom_dout;
    logic [15:0] ram_dout;
    logic [15:0] acc_dout;
    logic [15:0] rom_addr;
    logic [15:0] reg_dout;
    logic        iack;

    // Expected values for the step in flight
    logic        chk_en;
    logic [3:0]  test_idx;
    logic [15:0] exp_addr;
    logic [15:0] exp_reg;
    logic        reg_dc;
    logic        exp_iack;
    int          addr_errs;
    int          reg_errs;
    int          iack_errs;

    logic [15:0] pat [0:1023];      // Program image followed by steps
    int          n_steps     = 0;
    int          cycle_limit = 0;
    int          cycles      = 0;

    // Program memory answers in the same cycle
    assign rom_dout = (rom_addr < 16'h0100) ? pat[{2'b00, rom_addr[7:0]}] : 16'h0000;

    dsp_seq_top #(
        .RESET_PC (START_PC)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .cen            (cen),
        .rom_dout       (rom_dout),
        .ram_dout       (ram_dout),
        .acc_dout       (acc_dout),
        .ext_irq        (ext_irq),
        .irq_mask_clear (irq_mask_clear),
        .rom_addr       (rom_addr),
        .reg_dout       (reg_dout),
        .iack           (iack)
    );

    dsp_seq_checker u_checker (
        .clk       (clk),
        .chk_en    (chk_en),
        .test_idx  (test_idx),
        .exp_addr  (exp_addr),
        .exp_reg   (exp_reg),
        .reg_dc    (reg_dc),
        .exp_iack  (exp_iack),
        .rom_addr  (rom_addr),
        .reg_dout  (reg_dout),
        .iack      (iack),
        .addr_errs (addr_errs),
        .reg_errs  (reg_errs),
        .iack_errs (iack_errs)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the test steps did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int          seed;
        int          k;
        logic [9:0]  base;
        logic [15:0] ctl;

        seed           = $urandom(78827);
        rst            = 1'b1;
        cen            = 1'b1;
        ext_irq        = 1'b0;
        irq_mask_clear = 1'b0;
        ram_dout       = 16'h0000;
        acc_dout       = 16'h0000;
        chk_en         = 1'b0;
        test_idx       = 4'd0;
        exp_addr       = 16'h0000;
        exp_reg        = 16'h0000;
        reg_dc         = 1'b1;
        exp_iack       = 1'b0;

        for (k = 0; k < 1024; k++) begin
            pat[10'(k)] = {6'h3c, 10'(k)};     // Unused opcode that runs as nop
        end
        $readmemh("dv/seq_patterns.txt", pat);
        base = 10'(STEP_BASE);
        while (n_steps < MAX_STEPS && pat[base] != 16'hffff) begin
            n_steps++;
            base = 10'(STEP_BASE + STEP_WORDS * n_steps);
        end
        cycle_limit = 4 * n_steps + RESET_CYCLES;
        if (n_steps == 0) begin
            $display("the pattern file holds no test steps");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (k = 0; k < n_steps; k++) begin
            base           = 10'(STEP_BASE + STEP_WORDS * k);
            ctl            = pat[base];
            test_idx       = ctl[15:12];
            exp_iack       = ctl[5];
            irq_mask_clear = ctl[4];
            ext_irq        = ctl[3];
            cen            = ctl[2];
            reg_dc         = ctl[0];
            if (ctl[1]) begin
                ram_dout = 16'($urandom());     // Data nobody loads
                acc_dout = 16'($urandom());
            end else begin
                ram_dout = pat[base + 10'd1];
                acc_dout = pat[base + 10'd2];
            end
            exp_addr = pat[base + 10'd3];
            exp_reg  = pat[base + 10'd4];
            chk_en   = 1'b1;
            @(negedge clk);
        end
        chk_en = 1'b0;
        @(negedge clk);

        $display("error counts: address %0d, register %0d, iack %0d",
                 addr_errs, reg_errs, iack_errs);
        if (n_steps > 0 && addr_errs + reg_errs + iack_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* dv/dsp_seq_checker.sv */
`timescale 1ns/1ns

module dsp_seq_checker (
    input  logic        clk,
    input  logic        chk_en,
    input  logic [3:0]  test_idx,
    input  logic [15:0] exp_addr,
    input  logic [15:0] exp_reg,
    input  logic        reg_dc,     // Register read not compared
    input  logic        exp_iack,
    input  logic [15:0] rom_addr,
    input  logic [15:0] reg_dout,
    input  logic        iack,
    output int          addr_errs,
    output int          reg_errs,
    output int          iack_errs
);

    int n_addr = 0;
    int n_reg  = 0;
    int n_iack = 0;

    assign addr_errs = n_addr;
    assign reg_errs  = n_reg;
    assign iack_errs = n_iack;

    function automatic string test_name(input logic [3:0] idx);
        case (idx)
            4'd0:    return "seq_fetch";
            4'd1:    return "jump_call";
            4'd2:    return "reg_load";
            4'd3:    return "interrupt";
            4'd4:    return "do_loop";
            4'd5:    return "halt";
            default: return "unknown";
        endcase
    endfunction

    // Outputs are still the values of the cycle that ends here
    always @(posedge clk) begin
        if (chk_en) begin
            if (rom_addr !== exp_addr) begin
                n_addr <= n_addr + 1;
                $display("mismatch in %s: rom_addr expected %h actual %h at %0t",
                         test_name(test_idx), exp_addr, rom_addr, $time);
            end
            if (!reg_dc && reg_dout !== exp_reg) begin
                n_reg <= n_reg + 1;
                $display("mismatch in %s: reg_dout expected %h actual %h at %0t",
                         test_name(test_idx), exp_reg, reg_dout, $time);
            end
            if (iack !== exp_iack) begin
                n_iack <= n_iack + 1;
                $display("mismatch in %s: iack expected %b actual %b at %0t",
                         test_name(test_idx), exp_iack, iack, $time);
            end
        end
    end

endmodule

/* verilog/dsp_seq_top.sv */
`timescale 1ns/1ns

module dsp_seq_top import dsp_seq_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [15:0]       rom_dout,
    input  logic [15:0]       ram_dout,
    input  logic [15:0]       acc_dout,
    input  logic              ext_irq,
    input  logic              irq_mask_clear,
    output logic [ADDR_W-1:0] rom_addr,
    output logic [15:0]       reg_dout,
    output logic              iack
);

    seq_ctrl_t ctrl;    // Decoded strobes for the current word

    instr_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .cen            (cen),
        .rom_dout       (rom_dout),
        .irq_mask_clear (irq_mask_clear),
        .ctrl           (ctrl)
    );

    // Address unit drives the program memory port
    rom_aau #(
        .RESET_PC (RESET_PC)
    ) u_aau (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ctrl     (ctrl),
        .ext_irq  (ext_irq),
        .rom_dout (rom_dout),
        .ram_dout (ram_dout),
        .acc_dout (acc_dout),
        .iack     (iack),
        .rom_addr (rom_addr),
        .reg_dout (reg_dout)
    );

endmodule

/* verilog/rom_aau.sv */
`timescale 1ns/1ns

module rom_aau import dsp_seq_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  seq_ctrl_t         ctrl,
    input  logic              ext_irq,
    input  logic [15:0]       rom_dout,
    input  logic [15:0]       ram_dout,
    input  logic [15:0]       acc_dout,
    output logic              iack,
    output logic [ADDR_W-1:0] rom_addr,
    output logic [15:0]       reg_dout
);

    logic [ADDR_W-1:0] pc;       // Program counter
    logic [ADDR_W-1:0] pr;       // Return register
    logic [ADDR_W-1:0] pi;       // Interrupt return
    logic [ADDR_W-1:0] pt;       // Table pointer
    logic [11:0]       i;        // Signed index
    logic              shadow;   // Set outside interrupt service
    logic              do_en;
    logic [6:0]        do_left;
    logic [ADDR_W-1:0] do_head, do_end, do_exit;

    logic [ADDR_W-1:0] sequ_pc, next_norm, next_pc;
    logic [15:0]       i_ext, rnext;
    logic [2:0]        b_field;
    logic [3:0]        do_len;
    logic              ret, iret, goto_pt, call_pt, icall_go, copy_pc;
    logic              any_load, load_pt, load_pr, load_pi, load_i;
    logic              redo, do_endhit, do_last, enter_int;

    assign sequ_pc  = pc + ADDR_W'(1);
    assign i_ext    = {{4{i[11]}}, i};
    assign b_field  = ctrl.i_field[10:8];
    assign rom_addr = pc;

    // Jumps are ignored inside a loop body
    assign ret      = ctrl.goto_b && !do_en && b_field == 3'd0;
    assign iret     = ctrl.goto_b && !do_en && b_field == 3'd1;
    assign goto_pt  = ctrl.goto_b && !do_en && b_field == 3'd2;
    assign call_pt  = ctrl.goto_b && !do_en && b_field == 3'd3;
    assign icall_go = ctrl.icall && !do_en;
    assign copy_pc  = call_pt || (ctrl.call_ja && !do_en);

    assign any_load = ctrl.ram_load || ctrl.imm_load || ctrl.acc_load;
    assign load_pt  = (any_load && ctrl.r_field == 3'd0) || ctrl.post_inc;
    assign load_pr  = (any_load && ctrl.r_field == 3'd1) || copy_pc;
    assign load_pi  =  any_load && ctrl.r_field == 3'd2;
    assign load_i   =  any_load && ctrl.r_field == 3'd3;

    assign do_len    = ctrl.do_data[10:7];
    assign redo      = ctrl.do_start && do_len == 4'd0;
    assign do_endhit = do_en && pc == do_end;   // Last body word in flight
    assign do_last   = do_left <= 7'd1;

    assign enter_int = ext_irq && shadow && !do_en && !ctrl.pc_halt && !ctrl.no_int;

    always_comb begin
        if (ctrl.imm_load) begin
            rnext = rom_dout;
        end else if (ctrl.ram_load) begin
            rnext = ram_dout;
        end else if (ctrl.acc_load) begin
            rnext = acc_dout;
        end else if (copy_pc) begin
            rnext = sequ_pc;              // Return address of a call
        end else begin
            rnext = pt + i_ext;           // Post-increment
        end
    end

    always_comb begin
        case (ctrl.r_field[1:0])
            2'd0: reg_dout = pt;
            2'd1: reg_dout = pr;
            2'd2: reg_dout = pi;
            2'd3: reg_dout = i_ext;
        endcase
    end

    // Successor when no interrupt is taken
    always_comb begin
        if (ctrl.do_start) begin
            next_norm = redo ? do_head : sequ_pc;
        end else if (do_en) begin
            if (ctrl.pc_halt) begin
                next_norm = pc;
            end else if (do_endhit) begin
                next_norm = do_last ? do_exit : do_head;
            end else begin
                next_norm = sequ_pc;
            end
        end else if (icall_go) begin
            next_norm = ADDR_W'(2);
        end else if (ctrl.goto_ja || ctrl.call_ja) begin
            next_norm = {pc[ADDR_W-1:12], ctrl.i_field};
        end else if (goto_pt || call_pt) begin
            next_norm = pt;
        end else if (ret) begin
            next_norm = pr;
        end else if (iret) begin
            next_norm = pi;
        end else if (ctrl.pc_halt) begin
            next_norm = pc;
        end else begin
            next_norm = sequ_pc;
        end
    end

    assign next_pc = enter_int ? ADDR_W'(1) : next_norm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= RESET_PC;
            pr      <= '0;
            pi      <= '0;
            pt      <= '0;
            i       <= '0;
            shadow  <= 1'b1;
            iack    <= 1'b1;
            do_en   <= 1'b0;
            do_left <= '0;
        end else if (cen) begin
            pc   <= next_pc;
            iack <= enter_int;
            if (load_pt) pt <= rnext;
            if (load_pr) pr <= rnext;
            if (load_i)  i  <= rnext[11:0];

            // PI shadows the return point until service starts
            if (load_pi) begin
                pi <= rnext;
            end else if (shadow) begin
                pi <= icall_go ? sequ_pc : next_norm;
            end

            if (enter_int || icall_go) begin
                shadow <= 1'b0;
            end else if (iret) begin
                shadow <= 1'b1;
            end

            if (ctrl.do_start) begin
                do_en   <= 1'b1;
                do_left <= (ctrl.do_data[6:0] == 7'd0) ? 7'd1 : ctrl.do_data[6:0];
            end else if (do_endhit && !ctrl.pc_halt) begin
                if (do_last) begin
                    do_en   <= 1'b0;
                    do_left <= '0;
                end else begin
                    do_left <= do_left - 7'd1;
                end
            end
        end
    end

    // A redo keeps head and end and moves only the exit
    always_ff @(posedge clk) begin
        if (cen && ctrl.do_start) begin
            if (redo) begin
                do_exit <= sequ_pc;
            end else begin
                do_head <= sequ_pc;
                do_end  <= pc + ADDR_W'(do_len);
                do_exit <= pc + ADDR_W'(do_len) + ADDR_W'(1);
            end
        end
    end

    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        (cen && do_en && !ctrl.do_start) |=> do_left <= $past(do_left))
        else $error("loop counter wrapped below zero");

    a_iack_once: assert property (@(posedge clk) disable iff (rst)
        (cen && iack) |=> !iack)
        else $error("iack high for two enabled cycles");

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode import dsp_seq_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [15:0] rom_dout,
    input  logic        irq_mask_clear,
    output seq_ctrl_t   ctrl
);

    dec_state_t state, state_nxt;
    opcode_t    opcode;
    logic       imm_word;
    logic       mask;       // Sticky interrupt mask
    logic [2:0] r_hold;     // Destination of a pending immediate load

    assign opcode   = opcode_t'(rom_dout[15:12]);
    assign imm_word = state == st_imm_word;

    always_comb begin
        ctrl         = '0;
        ctrl.i_field = rom_dout[11:0];
        ctrl.do_data = rom_dout[10:0];
        ctrl.r_field = imm_word ? r_hold : rom_dout[10:8];
        ctrl.no_int  = mask;
        state_nxt    = st_opcode;
        if (imm_word) begin
            ctrl.imm_load = 1'b1;   // Current word is the data
        end else begin
            case (opcode)
                op_nop:      ctrl.post_inc = rom_dout[11];
                op_goto_ja:  ctrl.goto_ja  = 1'b1;
                op_call_ja:  ctrl.call_ja  = 1'b1;
                op_goto_b:   ctrl.goto_b   = 1'b1;
                op_icall: begin
                    ctrl.icall  = 1'b1;
                    ctrl.no_int = 1'b1;
                end
                op_load_imm: begin
                    // Interrupt here would fetch the vector as data
                    state_nxt   = st_imm_word;
                    ctrl.no_int = 1'b1;
                end
                op_load_ram: ctrl.ram_load = 1'b1;
                op_load_acc: ctrl.acc_load = 1'b1;
                op_do: begin
                    ctrl.do_start = 1'b1;
                    ctrl.no_int   = 1'b1;
                end
                op_halt:     ctrl.pc_halt  = 1'b1;
                op_no_int:   ctrl.no_int   = 1'b1;
                default: ;  // Unused codes run as nop
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_opcode;
            mask  <= 1'b0;
        end else if (cen) begin
            state <= state_nxt;
            if (!imm_word && opcode == op_no_int) begin
                mask <= 1'b1;
            end else if (irq_mask_clear) begin
                mask <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && !imm_word) begin
            r_hold <= rom_dout[10:8];
        end
    end

    a_one_load: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.ram_load, ctrl.imm_load, ctrl.acc_load}))
        else $error("more than one register load strobe active");

endmodule

/* verilog/dsp_seq_pkg.sv */
package dsp_seq_pkg;

    // Program address width fixed by the instruction set
    localparam int ADDR_W = 16;

    // Major opcode in bits 15:12 of the instruction word
    typedef enum logic [3:0] {
        op_nop      = 4'h0,  // Bit 11 set gives PT post-increment by I
        op_goto_ja  = 4'h1,  // Low 12 bits of PC from i_field
        op_call_ja  = 4'h2,
        op_goto_b   = 4'h3,  // Bits 10:8 pick return, iret, jump or call via PT
        op_icall    = 4'h4,
        op_load_imm = 4'h5,  // Data word follows
        op_load_ram = 4'h6,
        op_load_acc = 4'h7,
        op_do       = 4'h8,  // Bits 10:7 body length, 6:0 count
        op_halt     = 4'h9,
        op_no_int   = 4'ha   // Sets the sticky interrupt mask
    } opcode_t;

    // Decoder tracks the data word of an immediate load
    typedef enum logic {
        st_opcode   = 1'b0,
        st_imm_word = 1'b1
    } dec_state_t;

    // Strobes and fields from the decoder to the address unit
    typedef struct packed {
        logic        goto_ja;
        logic        goto_b;
        logic        call_ja;
        logic        icall;
        logic        post_inc;   // PT <= PT + I
        logic        pc_halt;
        logic        ram_load;
        logic        imm_load;
        logic        acc_load;
        logic        do_start;   // Do or redo
        logic        no_int;     // Blocks interrupt entry this cycle
        logic [10:0] do_data;
        logic [ 2:0] r_field;    // Register select for loads and reads
        logic [11:0] i_field;
    } seq_ctrl_t;

endpackage
